// ==== source/pg_params.svh ====
`ifndef PG_PARAMS_SVH
`define PG_PARAMS_SVH

// Beat layout
`define PG_LANES        4
`define PG_LANE_W       16
`define PG_DATA_W       64
`define PG_RULE_W       8
`define PG_RULES        256
`define PG_PORT_W       16

// Output buffering
`define PG_FIFO_DEPTH   32
`define PG_MAX_BEATS    8
// Depth minus beats in flight minus largest packet
`define PG_AF_LEVEL     20

`define PG_LANE_LAT     2
`define PG_APB_AW       12

`endif

// ==== source/pg_pkg.sv ====
`include "pg_params.svh"

package pg_pkg;

    typedef enum logic [1:0] {
        PROTO_ANY = 2'd0,
        PROTO_TCP = 2'd1,
        PROTO_UDP = 2'd2
    } proto_t;

    typedef enum logic {
        PS_IDLE,
        PS_RULE
    } parse_state_t;

    // Zero port means any port
    typedef struct packed {
        proto_t                 proto;
        logic [`PG_PORT_W-1:0]  sport;
        logic [`PG_PORT_W-1:0]  dport;
    } rule_entry_t;

endpackage

// ==== source/pg_apb_cfg.sv ====
`timescale 1ns/1ns
`include "pg_params.svh"

module pg_apb_cfg import pg_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`PG_APB_AW-1:0]   paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic                    pready,
    output logic                    tbl_we,
    output logic [`PG_RULE_W-1:0]   tbl_addr,
    output rule_entry_t             tbl_entry
);

    logic                       wr_access;
    logic                       addr_in_range;
    logic [2:0]                 word_off;
    logic [`PG_RULE_W-1:0]      rule_idx;
    logic [2*`PG_PORT_W-1:0]    port_stage;

    // Zero wait states
    assign pready = psel && penable;

    assign word_off      = paddr[2:0];
    assign rule_idx      = paddr[3 +: `PG_RULE_W];
    assign addr_in_range = (paddr[`PG_APB_AW-1:`PG_RULE_W+3] == '0);
    assign wr_access     = psel && penable && pwrite && addr_in_range;

    always_ff @(posedge clk) begin
        if (rst) begin
            tbl_we <= 1'b0;
        end else begin
            tbl_we <= wr_access && (word_off == 3'd4);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_access && (word_off == 3'd0)) begin
            port_stage <= pwdata;
        end
        // Proto word commits the staged ports with it
        if (wr_access && (word_off == 3'd4)) begin
            tbl_addr        <= rule_idx;
            tbl_entry.proto <= proto_t'(pwdata[1:0]);
            tbl_entry.sport <= port_stage[2*`PG_PORT_W-1:`PG_PORT_W];
            tbl_entry.dport <= port_stage[`PG_PORT_W-1:0];
        end
    end

endmodule

// ==== source/pg_parser.sv ====
`timescale 1ns/1ns
`include "pg_params.svh"

module pg_parser import pg_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    meta_valid,
    input  proto_t                                  meta_proto,
    input  logic [`PG_PORT_W-1:0]                   meta_sport,
    input  logic [`PG_PORT_W-1:0]                   meta_dport,
    input  logic                                    in_valid,
    input  logic [`PG_DATA_W-1:0]                   in_data,
    input  logic                                    in_eop,
    input  logic                                    almost_full,
    output logic                                    meta_ready,
    output logic                                    in_ready,
    output logic                                    lane_valid,
    output logic                                    lane_eop,
    output logic [`PG_LANES-1:0][`PG_RULE_W-1:0]    lane_rule,
    output proto_t                                  pkt_proto,
    output logic [`PG_PORT_W-1:0]                   pkt_sport,
    output logic [`PG_PORT_W-1:0]                   pkt_dport
);

    parse_state_t   state;
    logic           start;
    logic           beat;

    // meta_ready high means the word is being consumed this cycle
    assign start    = (state == PS_IDLE) && meta_valid && !meta_ready && !almost_full;
    assign in_ready = (state == PS_RULE);
    assign beat     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= PS_IDLE;
            meta_ready <= 1'b0;
            lane_valid <= 1'b0;
            lane_eop   <= 1'b0;
        end else begin
            meta_ready <= 1'b0;
            lane_valid <= beat;
            lane_eop   <= beat && in_eop;
            case (state)
                PS_IDLE: begin
                    if (start) begin
                        state <= PS_RULE;
                    end
                end
                PS_RULE: begin
                    if (beat && in_eop) begin
                        state      <= PS_IDLE;
                        meta_ready <= 1'b1;
                    end
                end
                default: state <= PS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pkt_proto <= meta_proto;
            pkt_sport <= meta_sport;
            pkt_dport <= meta_dport;
        end
        // Rule ID sits in the low bits of each lane
        if (beat) begin
            for (int i = 0; i < `PG_LANES; i++) begin
                lane_rule[i] <= in_data[i*`PG_LANE_W +: `PG_RULE_W];
            end
        end
    end

endmodule

// ==== source/pg_rule_lane.sv ====
`timescale 1ns/1ns
`include "pg_params.svh"

module pg_rule_lane import pg_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tbl_we,
    input  logic [`PG_RULE_W-1:0]   tbl_addr,
    input  rule_entry_t             tbl_entry,
    input  logic [`PG_RULE_W-1:0]   lane_rule,
    input  proto_t                  pkt_proto,
    input  logic [`PG_PORT_W-1:0]   pkt_sport,
    input  logic [`PG_PORT_W-1:0]   pkt_dport,
    output logic                    match,
    output logic [`PG_RULE_W-1:0]   out_rule
);

    rule_entry_t                rule_tbl [`PG_RULES];
    rule_entry_t                entry_q;
    logic [`PG_RULE_W-1:0]      rule_q;
    logic                       hit;

    // Local copy, every lane sees the same broadcast write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PG_RULES; i++) begin
                rule_tbl[i] <= '0;
            end
        end else if (tbl_we) begin
            rule_tbl[tbl_addr] <= tbl_entry;
        end
    end

    // Stage 1 lookup
    always_ff @(posedge clk) begin
        entry_q <= rule_tbl[lane_rule];
        rule_q  <= lane_rule;
    end

    // Metadata is still held for this packet here
    assign hit = (rule_q != '0)
              && ((entry_q.proto == PROTO_ANY) || (entry_q.proto == pkt_proto))
              && ((entry_q.sport == '0) || (entry_q.sport == pkt_sport))
              && ((entry_q.dport == '0) || (entry_q.dport == pkt_dport));

    // Stage 2 result
    always_ff @(posedge clk) begin
        if (rst) begin
            match <= 1'b0;
        end else begin
            match <= hit;
        end
        out_rule <= hit ? rule_q : '0;
    end

endmodule

// ==== source/pg_collector.sv ====
`timescale 1ns/1ns
`include "pg_params.svh"

module pg_collector (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    lane_valid,
    input  logic                                    lane_eop,
    input  logic [`PG_LANES-1:0]                    match,
    input  logic [`PG_LANES-1:0][`PG_RULE_W-1:0]    out_rule,
    output logic                                    wr_valid,
    output logic [`PG_DATA_W-1:0]                   wr_data,
    output logic                                    wr_sop,
    output logic                                    wr_eop,
    output logic [31:0]                             rule_beat_cnt,
    output logic [31:0]                             match_beat_cnt
);

    logic [`PG_LANE_LAT-1:0]    valid_sr;
    logic [`PG_LANE_LAT-1:0]    eop_sr;
    logic                       beat_valid;
    logic                       beat_eop;
    logic                       keep;
    logic                       sop_pend;

    // Line up with the lane lookup pipeline
    assign beat_valid = valid_sr[`PG_LANE_LAT-1];
    assign beat_eop   = eop_sr[`PG_LANE_LAT-1];
    // eop beat survives even with nothing matched
    assign keep       = beat_valid && ((|match) || beat_eop);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr       <= '0;
            eop_sr         <= '0;
            wr_valid       <= 1'b0;
            wr_eop         <= 1'b0;
            wr_sop         <= 1'b0;
            sop_pend       <= 1'b1;
            rule_beat_cnt  <= '0;
            match_beat_cnt <= '0;
        end else begin
            valid_sr <= {valid_sr[`PG_LANE_LAT-2:0], lane_valid};
            eop_sr   <= {eop_sr[`PG_LANE_LAT-2:0], lane_eop};
            wr_valid <= keep;
            wr_eop   <= keep && beat_eop;
            wr_sop   <= keep && sop_pend;
            if (keep) begin
                sop_pend <= beat_eop;
            end
            if (beat_valid && !beat_eop) begin
                rule_beat_cnt <= rule_beat_cnt + 32'd1;
            end
            if (wr_valid && !wr_eop) begin
                match_beat_cnt <= match_beat_cnt + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `PG_LANES; i++) begin
            wr_data[i*`PG_LANE_W +: `PG_LANE_W] <=
                {{(`PG_LANE_W-`PG_RULE_W){1'b0}}, out_rule[i]};
        end
    end

endmodule

// ==== source/pg_fifo.sv ====
`timescale 1ns/1ns
`include "pg_params.svh"

module pg_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_valid,
    input  logic [`PG_DATA_W-1:0]   wr_data,
    input  logic                    wr_sop,
    input  logic                    wr_eop,
    input  logic                    out_ready,
    output logic                    out_valid,
    output logic [`PG_DATA_W-1:0]   out_data,
    output logic                    out_sop,
    output logic                    out_eop,
    output logic                    almost_full
);

    localparam int AW = $clog2(`PG_FIFO_DEPTH);

    // Word is {sop, eop, data}
    logic [`PG_DATA_W+1:0]  mem [`PG_FIFO_DEPTH];
    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic [AW:0]            count;
    logic                   rd_en;

    assign rd_en       = out_valid && out_ready;
    assign out_valid   = (count != '0);
    assign almost_full = (count >= (AW+1)'(`PG_AF_LEVEL));
    assign {out_sop, out_eop, out_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= {wr_sop, wr_eop, wr_data};
        end
    end

    // Space is guaranteed by upstream throttling
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            case ({wr_valid, rd_en})
                2'b10:   count <= count + (AW+1)'(1);
                2'b01:   count <= count - (AW+1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/port_group_filter.sv ====
`timescale 1ns/1ns
`include "pg_params.svh"

module port_group_filter import pg_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // APB config
    input  logic [`PG_APB_AW-1:0]   paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic                    pready,
    // Metadata
    input  logic                    meta_valid,
    input  proto_t                  meta_proto,
    input  logic [`PG_PORT_W-1:0]   meta_sport,
    input  logic [`PG_PORT_W-1:0]   meta_dport,
    output logic                    meta_ready,
    // Input beats
    input  logic                    in_valid,
    input  logic [`PG_DATA_W-1:0]   in_data,
    input  logic                    in_eop,
    output logic                    in_ready,
    // Output beats
    output logic                    out_valid,
    output logic [`PG_DATA_W-1:0]   out_data,
    output logic                    out_sop,
    output logic                    out_eop,
    input  logic                    out_ready,
    // Statistics
    output logic [31:0]             rule_beat_cnt,
    output logic [31:0]             match_beat_cnt
);

    logic                                   tbl_we;
    logic [`PG_RULE_W-1:0]                  tbl_addr;
    rule_entry_t                            tbl_entry;
    logic                                   lane_valid;
    logic                                   lane_eop;
    logic [`PG_LANES-1:0][`PG_RULE_W-1:0]   lane_rule;
    proto_t                                 pkt_proto;
    logic [`PG_PORT_W-1:0]                  pkt_sport;
    logic [`PG_PORT_W-1:0]                  pkt_dport;
    logic [`PG_LANES-1:0]                   lane_match;
    logic [`PG_LANES-1:0][`PG_RULE_W-1:0]   lane_out_rule;
    logic                                   wr_valid;
    logic [`PG_DATA_W-1:0]                  wr_data;
    logic                                   wr_sop;
    logic                                   wr_eop;
    logic                                   almost_full;

    pg_apb_cfg i_apb_cfg (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pready    (pready),
        .tbl_we    (tbl_we),
        .tbl_addr  (tbl_addr),
        .tbl_entry (tbl_entry)
    );

    pg_parser i_parser (
        .clk         (clk),
        .rst         (rst),
        .meta_valid  (meta_valid),
        .meta_proto  (meta_proto),
        .meta_sport  (meta_sport),
        .meta_dport  (meta_dport),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_eop      (in_eop),
        .almost_full (almost_full),
        .meta_ready  (meta_ready),
        .in_ready    (in_ready),
        .lane_valid  (lane_valid),
        .lane_eop    (lane_eop),
        .lane_rule   (lane_rule),
        .pkt_proto   (pkt_proto),
        .pkt_sport   (pkt_sport),
        .pkt_dport   (pkt_dport)
    );

    for (genvar i = 0; i < `PG_LANES; i++) begin : g_lane
        pg_rule_lane i_lane (
            .clk       (clk),
            .rst       (rst),
            .tbl_we    (tbl_we),
            .tbl_addr  (tbl_addr),
            .tbl_entry (tbl_entry),
            .lane_rule (lane_rule[i]),
            .pkt_proto (pkt_proto),
            .pkt_sport (pkt_sport),
            .pkt_dport (pkt_dport),
            .match     (lane_match[i]),
            .out_rule  (lane_out_rule[i])
        );
    end

    pg_collector i_collector (
        .clk            (clk),
        .rst            (rst),
        .lane_valid     (lane_valid),
        .lane_eop       (lane_eop),
        .match          (lane_match),
        .out_rule       (lane_out_rule),
        .wr_valid       (wr_valid),
        .wr_data        (wr_data),
        .wr_sop         (wr_sop),
        .wr_eop         (wr_eop),
        .rule_beat_cnt  (rule_beat_cnt),
        .match_beat_cnt (match_beat_cnt)
    );

    pg_fifo i_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_valid    (wr_valid),
        .wr_data     (wr_data),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_sop     (out_sop),
        .out_eop     (out_eop),
        .almost_full (almost_full)
    );

endmodule

// ==== tb/tb_port_group_filter.sv ====
`timescale 1ns/1ns
`include "pg_params.svh"

module tb_port_group_filter import pg_pkg::*; ();

    logic                       clk;
    logic                       rst = 1'b1;
    logic [`PG_APB_AW-1:0]      paddr = '0;
    logic                       psel = 1'b0;
    logic                       penable = 1'b0;
    logic                       pwrite = 1'b0;
    logic [31:0]                pwdata = '0;
    logic                       pready;
    logic                       meta_valid = 1'b0;
    proto_t                     meta_proto = PROTO_TCP;
    logic [`PG_PORT_W-1:0]      meta_sport = '0;
    logic [`PG_PORT_W-1:0]      meta_dport = '0;
    logic                       meta_ready;
    logic                       in_valid = 1'b0;
    logic [`PG_DATA_W-1:0]      in_data = '0;
    logic                       in_eop = 1'b0;
    logic                       in_ready;
    logic                       out_valid;
    logic [`PG_DATA_W-1:0]      out_data;
    logic                       out_sop;
    logic                       out_eop;
    logic                       out_ready = 1'b1;
    logic [31:0]                rule_beat_cnt;
    logic [31:0]                match_beat_cnt;

    rule_entry_t                tbl_mirror [`PG_RULES];
    // Expected beats as {sop, eop, data}
    logic [`PG_DATA_W+1:0]      exp_mem [1024];
    logic [`PG_DATA_W+1:0]      exp_word;
    logic [9:0]                 wr_idx = '0;
    logic [9:0]                 rd_idx;
    logic                       sop_pend = 1'b1;
    logic [31:0]                exp_rule_beats = '0;
    logic [31:0]                exp_match_beats = '0;
    logic [31:0]                meta_pulses;
    logic [31:0]                pkts_sent = '0;
    logic [`PG_DATA_W-1:0]      pkt_beats [`PG_MAX_BEATS];
    logic [15:0]                port_pool [6] = '{16'd80, 16'd443, 16'd53, 16'd1000,
                                                  16'd2000, 16'd8080};
    int                         beats_sent = 0;
    int                         cycles = 0;
    int                         rdy_mode = 0;
    int                         hold_cnt = 0;

    port_group_filter i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
            input logic [63:0] exp);
        stop_run($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    endtask

    function automatic logic lane_hits(input logic [`PG_RULE_W-1:0] rule, input proto_t proto,
            input logic [15:0] sport, input logic [15:0] dport);
        rule_entry_t e;
        e = tbl_mirror[rule];
        return (rule != '0) && (e.proto == PROTO_ANY || e.proto == proto)
            && (e.sport == '0 || e.sport == sport) && (e.dport == '0 || e.dport == dport);
    endfunction

    function automatic logic [15:0] pick_port();
        logic [2:0] k;
        k = 3'($urandom % 6);
        return port_pool[k];
    endfunction

    // Low byte of each lane picks a rule from 0 to 23 and the high byte is noise
    function automatic logic [`PG_DATA_W-1:0] random_beat();
        logic [`PG_DATA_W-1:0] d;
        int i;
        for (i = 0; i < `PG_LANES; i++) begin
            d[i*`PG_LANE_W +: `PG_LANE_W] = {8'($urandom), 8'($urandom % 24)};
        end
        return d;
    endfunction

    task automatic expect_beat(input logic [`PG_DATA_W-1:0] data, input logic eop);
        logic [`PG_DATA_W-1:0] res;
        logic [`PG_RULE_W-1:0] rule;
        logic any;
        int i;
        res = '0;
        any = 1'b0;
        for (i = 0; i < `PG_LANES; i++) begin
            rule = data[i*`PG_LANE_W +: `PG_RULE_W];
            if (lane_hits(rule, meta_proto, meta_sport, meta_dport)) begin
                res[i*`PG_LANE_W +: `PG_RULE_W] = rule;
                any = 1'b1;
            end
        end
        if (!eop) begin
            exp_rule_beats = exp_rule_beats + 32'd1;
        end
        if (any && !eop) begin
            exp_match_beats = exp_match_beats + 32'd1;
        end
        if (any || eop) begin
            exp_mem[wr_idx] = {sop_pend, eop, res};
            wr_idx = wr_idx + 10'd1;
            sop_pend = eop;
        end
    endtask

    task automatic apb_write(input logic [`PG_APB_AW-1:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        assert (pready) else report_mismatch("pready", 64'(pready), 64'd1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic program_rule(input logic [7:0] idx, input proto_t proto,
            input logic [15:0] sport, input logic [15:0] dport);
        apb_write({1'b0, idx, 3'd0}, {sport, dport});
        apb_write({1'b0, idx, 3'd4}, {30'd0, proto});
        tbl_mirror[idx].proto = proto;
        tbl_mirror[idx].sport = sport;
        tbl_mirror[idx].dport = dport;
    endtask

    task automatic send_beat(input logic [`PG_DATA_W-1:0] data, input logic eop);
        if (rdy_mode != 0 && $urandom % 4 == 0) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_data  = data;
        in_eop   = eop;
        do @(negedge clk); while (!in_ready);
        @(posedge clk);
        expect_beat(data, eop);
        #1;
        beats_sent = beats_sent + 1;
        in_valid = 1'b0;
        in_eop   = 1'b0;
    endtask

    // Metadata stays up until its meta_ready pulse
    task automatic send_packet(input proto_t proto, input logic [15:0] sport,
            input logic [15:0] dport, input int nbeats);
        int b;
        meta_valid = 1'b1;
        meta_proto = proto;
        meta_sport = sport;
        meta_dport = dport;
        for (b = 0; b < nbeats; b++) begin
            send_beat(pkt_beats[b[2:0]], b == nbeats - 1);
        end
        do @(negedge clk); while (!meta_ready);
        @(posedge clk);
        #1;
        meta_valid = 1'b0;
        pkts_sent  = pkts_sent + 32'd1;
    endtask

    task automatic send_random_packets(input int count);
        int p;
        int n;
        int b;
        for (p = 0; p < count; p++) begin
            n = 1 + int'($urandom % `PG_MAX_BEATS);
            for (b = 0; b < n; b++) begin
                pkt_beats[b[2:0]] = random_beat();
            end
            send_packet(proto_t'(2'(1 + $urandom % 2)), pick_port(), pick_port(), n);
        end
    endtask

    assign exp_word = exp_mem[rd_idx];

    always @(posedge clk) begin
        if (rst) begin
            rd_idx <= '0;
        end else if (out_valid && out_ready) begin
            rd_idx <= rd_idx + 10'd1;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            meta_pulses <= '0;
        end else if (meta_ready) begin
            meta_pulses <= meta_pulses + 32'd1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 40 * beats_sent + 2000) begin
            stop_run("Timeout, the run went past its cycle limit");
        end
    end

    // Output sink stalls for long stretches only in mode 2
    always begin
        @(posedge clk);
        #1;
        if (rdy_mode == 0) begin
            out_ready = 1'b1;
        end else if (hold_cnt > 0) begin
            out_ready = 1'b0;
            hold_cnt  = hold_cnt - 1;
        end else begin
            out_ready = ($urandom % 3) != 0;
            if (rdy_mode == 2 && $urandom % 16 == 0) begin
                hold_cnt = 20 + int'($urandom % 40);
            end
        end
    end

    a_expected: assert property (@(negedge clk) disable iff (rst)
            out_valid |-> (wr_idx != rd_idx))
        else stop_run("Output beat appeared while no beat was expected");
    a_data: assert property (@(negedge clk) disable iff (rst)
            (out_valid && out_ready) |-> (out_data == exp_word[`PG_DATA_W-1:0]))
        else report_mismatch("out_data", out_data, exp_word[`PG_DATA_W-1:0]);
    a_sop: assert property (@(negedge clk) disable iff (rst)
            (out_valid && out_ready) |-> (out_sop == exp_word[`PG_DATA_W+1]))
        else report_mismatch("out_sop", 64'(out_sop), 64'(exp_word[`PG_DATA_W+1]));
    a_eop: assert property (@(negedge clk) disable iff (rst)
            (out_valid && out_ready) |-> (out_eop == exp_word[`PG_DATA_W]))
        else report_mismatch("out_eop", 64'(out_eop), 64'(exp_word[`PG_DATA_W]));

    initial begin
        int i;
        int k;
        void'($urandom(32'h0aa4f759));
        for (i = 0; i < `PG_RULES; i++) begin
            tbl_mirror[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!in_ready) else report_mismatch("in_ready", 64'(in_ready), 64'd0);
        assert (!meta_ready) else report_mismatch("meta_ready", 64'(meta_ready), 64'd0);
        assert (!out_valid) else report_mismatch("out_valid", 64'(out_valid), 64'd0);
        assert (!pready) else report_mismatch("pready", 64'(pready), 64'd0);
        assert (rule_beat_cnt == '0)
            else report_mismatch("rule_beat_cnt", 64'(rule_beat_cnt), 64'd0);
        assert (match_beat_cnt == '0)
            else report_mismatch("match_beat_cnt", 64'(match_beat_cnt), 64'd0);
        @(posedge clk);
        #1;

        program_rule(8'd1, PROTO_TCP, 16'd80, 16'd0);
        program_rule(8'd2, PROTO_UDP, 16'd0, 16'd53);
        program_rule(8'd3, PROTO_ANY, 16'd1000, 16'd2000);
        program_rule(8'd4, PROTO_TCP, 16'd443, 16'd8080);
        program_rule(8'd5, PROTO_UDP, 16'd0, 16'd0);
        program_rule(8'd6, PROTO_TCP, 16'd0, 16'd0);
        program_rule(8'd7, PROTO_ANY, 16'd0, 16'd443);
        program_rule(8'd8, PROTO_ANY, 16'd53, 16'd0);
        for (k = 9; k < 16; k++) begin
            program_rule(8'(k), proto_t'(2'($urandom % 3)),
                ($urandom % 2 == 0) ? 16'd0 : pick_port(),
                ($urandom % 2 == 0) ? 16'd0 : pick_port());
        end
        // Port 7 never shows up in the metadata
        for (k = 16; k < 24; k++) begin
            program_rule(8'(k), PROTO_TCP, 16'd7, 16'd0);
        end

        // Directed packets with the sink always ready
        pkt_beats[0] = {16'h0007, 16'h0002, 16'h0004, 16'h0001};
        pkt_beats[1] = {16'hff02, 16'h0000, 16'h1102, 16'h0004};
        pkt_beats[2] = {16'h0000, 16'h0003, 16'h0000, 16'h0001};
        send_packet(PROTO_TCP, 16'd80, 16'd443, 3);
        pkt_beats[0] = {16'h0000, 16'h0000, 16'h0004, 16'h0001};
        pkt_beats[1] = {16'h0006, 16'h0000, 16'h0000, 16'h0000};
        send_packet(PROTO_UDP, 16'd1000, 16'd80, 2);
        pkt_beats[0] = {16'h0000, 16'h0002, 16'h0000, 16'h0004};
        send_packet(PROTO_TCP, 16'd443, 16'd8080, 1);

        rdy_mode = 1;
        send_random_packets(40);
        rdy_mode = 2;
        send_random_packets(40);

        rdy_mode = 0;
        i = 0;
        while (wr_idx != rd_idx && i < 500) begin
            @(posedge clk);
            i = i + 1;
        end
        repeat (4) @(negedge clk);
        assert (wr_idx == rd_idx) else stop_run("Expected beats never left the DUT");
        assert (!out_valid) else report_mismatch("out_valid", 64'(out_valid), 64'd0);
        assert (rule_beat_cnt == exp_rule_beats)
            else report_mismatch("rule_beat_cnt", 64'(rule_beat_cnt), 64'(exp_rule_beats));
        assert (match_beat_cnt == exp_match_beats)
            else report_mismatch("match_beat_cnt", 64'(match_beat_cnt), 64'(exp_match_beats));
        assert (meta_pulses == pkts_sent)
            else report_mismatch("meta_ready pulses", 64'(meta_pulses), 64'(pkts_sent));
        $display("Test OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/pg_pkg.sv
source/pg_apb_cfg.sv
source/pg_parser.sv
source/pg_rule_lane.sv
source/pg_collector.sv
source/pg_fifo.sv
source/port_group_filter.sv
tb/tb_port_group_filter.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_port_group_filter
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
